// ==== logic/adc_demo_pkg.sv ====
// ADC demo shared widths, rates, word types, strobe structs and flow states
package adc_demo_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and rates
   ////////////////////////////////////////////////////////////
   localparam int DATA_W           = 16;          // USB and buffer word
   localparam int BLK_ADDR_W       = 10;          // 1024 words per block
   localparam int SDRAM_ADDR_W     = 16;
   localparam int BLK_IDX_W        = SDRAM_ADDR_W - BLK_ADDR_W;

   localparam int MCLK_RATE        = 120_000_000;
   localparam int SPCLK_RATE       = 200_000;

   // Sync output shape
   localparam int SPCLK_PER_FRAME  = 512;
   localparam int FRAMES_PER_CYCLE = 105;
   localparam int SYNC_MUTE_FIRST  = 100;         // Sync suppressed from here to cycle end
   localparam int DATA_HIGH_SPCLKS = 270;
   localparam int SP_CNT_W         = $clog2(SPCLK_PER_FRAME);
   localparam int FRAME_CNT_W      = $clog2(FRAMES_PER_CYCLE);

   // Transmit buffer halves
   localparam logic HALF_REPLY     = 1'b0;
   localparam logic HALF_BLOCK     = 1'b1;

   typedef logic [DATA_W-1:0]       word_t;
   typedef logic [BLK_ADDR_W-1:0]   blk_addr_t;
   typedef logic [SDRAM_ADDR_W-1:0] sdram_addr_t;   // Upper bits are the block index

   typedef struct packed {
      logic        vd;
      logic        sdram_mode;   // High for block write and read-out
      sdram_addr_t addr;
   } cmd_t;

   typedef struct packed {
      logic        rd;
      sdram_addr_t raddr;
   } sdram_rd_t;

   typedef struct packed {
      logic        wren;
      sdram_addr_t waddr;
      word_t       wdata;
   } sdram_wr_t;

   typedef enum logic [1:0] {
      ST_IDLE  = 2'b00,
      ST_CMD   = 2'b01,
      ST_SDRAM = 2'b11,
      ST_TXBUF = 2'b10
   } flow_state_e;

endpackage

// ==== logic/sync_out_gen.sv ====
// Test-signal generator producing the sample clock, frame sync and data level
`timescale 1ns/1ps

module sync_out_gen
   import adc_demo_pkg::*;
#(
   parameter int SPCLK_DIV = 2
) (
   input  logic mclk,
   input  logic rst_i,
   output logic spclk_o,
   output logic sync_o,
   output logic data_o
);

   localparam int DIV_W = $clog2(SPCLK_DIV);

   localparam logic [DIV_W-1:0]       DIV_LAST   = DIV_W'(SPCLK_DIV - 1);
   localparam logic [DIV_W-1:0]       DIV_HALF   = DIV_W'(SPCLK_DIV / 2);
   localparam logic [SP_CNT_W-1:0]    SP_LAST    = SP_CNT_W'(SPCLK_PER_FRAME - 1);
   localparam logic [SP_CNT_W-1:0]    DATA_END   = SP_CNT_W'(DATA_HIGH_SPCLKS);
   localparam logic [FRAME_CNT_W-1:0] FRAME_LAST = FRAME_CNT_W'(FRAMES_PER_CYCLE - 1);
   localparam logic [FRAME_CNT_W-1:0] MUTE_FIRST = FRAME_CNT_W'(SYNC_MUTE_FIRST);

   logic [DIV_W-1:0]       div_cnt;
   logic [SP_CNT_W-1:0]    sp_cnt;      // Sample clock within frame
   logic [FRAME_CNT_W-1:0] frame_cnt;   // Frame within sync cycle

   ////////////////////////////////////////////////////////////
   // Counters
   ////////////////////////////////////////////////////////////
   always_ff @(posedge mclk) begin
      if (rst_i) begin
         div_cnt   <= '0;
         sp_cnt    <= '0;
         frame_cnt <= '0;
      end else if (div_cnt == DIV_LAST) begin
         div_cnt <= '0;
         if (sp_cnt == SP_LAST) begin
            sp_cnt <= '0;
            if (frame_cnt == FRAME_LAST)
               frame_cnt <= '0;
            else
               frame_cnt <= frame_cnt + 1'b1;
         end else begin
            sp_cnt <= sp_cnt + 1'b1;
         end
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Registered outputs
   ////////////////////////////////////////////////////////////
   always_ff @(posedge mclk) begin
      if (rst_i) begin
         spclk_o <= 1'b0;
         sync_o  <= 1'b0;
         data_o  <= 1'b0;
      end else begin
         spclk_o <= (div_cnt < DIV_HALF);                    // High in first half period
         sync_o  <= (sp_cnt == '0) && (frame_cnt < MUTE_FIRST);
         data_o  <= (sp_cnt < DATA_END);
      end
   end

   // Frame count wraps before the cycle length
   a_frame_range : assert property (
      @(posedge mclk) disable iff (rst_i)
      frame_cnt < FRAME_CNT_W'(FRAMES_PER_CYCLE)
   );

endmodule

// ==== logic/tx_block_buffer.sv ====
// Two-half transmit buffer with one write port and a registered read port
`timescale 1ns/1ps

module tx_block_buffer
   import adc_demo_pkg::*;
(
   input  logic                mclk,
   input  logic                we_i,
   input  logic [BLK_ADDR_W:0] waddr_i,     // Half bit on top
   input  word_t               wdata_i,
   input  logic                rhalf_i,
   input  blk_addr_t           raddr_i,
   output word_t               rdata_o
);

   localparam int DEPTH = 2 ** (BLK_ADDR_W + 1);

   // Lower half holds replies, upper half SDRAM blocks
   word_t mem [DEPTH];

   always_ff @(posedge mclk) begin
      if (we_i)
         mem[waddr_i] <= wdata_i;
   end

   always_ff @(posedge mclk) begin
      rdata_o <= mem[{rhalf_i, raddr_i}];   // One cycle after address
   end

endmodule

// ==== logic/tx_flow_ctrl.sv ====
// Transmit flow controller moving command data through SDRAM read-out to the USB sender
`timescale 1ns/1ps

module tx_flow_ctrl
   import adc_demo_pkg::*;
(
   input  logic                mclk,
   input  logic                rst_i,
   input  logic                acq_en_i,
   input  cmd_t                cmd_i,
   input  word_t               cmd_data_i,
   input  logic                sdram_wstatus_i,
   input  logic                sdram_rdv_i,
   input  word_t               sdram_rdata_i,
   input  logic                usb_full_i,
   input  logic                usb_tx_eop_i,
   output sdram_wr_t           sdram_wr_o,
   output sdram_rd_t           sdram_rd_o,
   output logic                usb_tx_sop_o,
   output logic                usb_tx_half_o,
   output logic                buf_we_o,
   output logic [BLK_ADDR_W:0] buf_waddr_o,
   output word_t               buf_wdata_o
);

   localparam blk_addr_t BLK_LAST = '1;

   flow_state_e            state_q;
   sdram_addr_t            raddr_q;      // Address of last issued read
   logic [BLK_IDX_W-1:0]   blk_q;        // Next block to read out
   blk_addr_t              fill_q;       // Returned words in this block
   logic                   rd_q;
   logic                   wstat_q;
   logic [1:0]             eop_q;
   logic                   cmd_mode_q;
   logic [BLK_IDX_W-1:0]   cmd_blk_q;

   logic                   wstat_rise;
   logic                   eop_seen;
   logic                   dir_we;
   logic                   blk_match;

   assign wstat_rise = sdram_wstatus_i & ~wstat_q;
   assign eop_seen   = eop_q[1];                              // EOP two cycles late
   assign blk_match  = (raddr_q[SDRAM_ADDR_W-1 -: BLK_IDX_W] == cmd_blk_q);

   ////////////////////////////////////////////////////////////
   // Command forwarding and buffer write port
   ////////////////////////////////////////////////////////////
   assign sdram_wr_o.wren  = cmd_i.vd & cmd_i.sdram_mode;
   assign sdram_wr_o.waddr = cmd_i.addr;
   assign sdram_wr_o.wdata = cmd_data_i;

   assign sdram_rd_o.rd    = rd_q;
   assign sdram_rd_o.raddr = raddr_q;

   // SDRAM words take the block half, direct words the reply half
   assign dir_we      = cmd_i.vd & ~cmd_i.sdram_mode;
   assign buf_we_o    = sdram_rdv_i | dir_we;
   assign buf_waddr_o = sdram_rdv_i ? {HALF_BLOCK, fill_q}
                                    : {HALF_REPLY, cmd_i.addr[BLK_ADDR_W-1:0]};
   assign buf_wdata_o = sdram_rdv_i ? sdram_rdata_i : cmd_data_i;

   ////////////////////////////////////////////////////////////
   // Flow FSM
   ////////////////////////////////////////////////////////////
   always_ff @(posedge mclk) begin
      if (rst_i) begin
         state_q       <= ST_IDLE;
         raddr_q       <= '0;
         blk_q         <= '0;
         fill_q        <= '0;
         rd_q          <= 1'b0;
         wstat_q       <= 1'b0;
         eop_q         <= '0;
         cmd_mode_q    <= 1'b0;
         cmd_blk_q     <= '0;
         usb_tx_sop_o  <= 1'b0;
         usb_tx_half_o <= HALF_REPLY;
      end else begin
         rd_q         <= 1'b0;
         usb_tx_sop_o <= 1'b0;
         wstat_q      <= sdram_wstatus_i;
         eop_q        <= {eop_q[0], usb_tx_eop_i};

         case (state_q)
            ST_IDLE: begin
               fill_q <= '0;
               if (cmd_i.vd) begin
                  state_q    <= ST_CMD;
                  cmd_mode_q <= cmd_i.sdram_mode;
                  cmd_blk_q  <= cmd_i.addr[SDRAM_ADDR_W-1 -: BLK_IDX_W];
               end
            end
            ST_CMD: begin
               if (cmd_mode_q) begin
                  usb_tx_half_o <= HALF_BLOCK;
                  if (wstat_rise) begin                       // Write landed in SDRAM
                     state_q <= ST_SDRAM;
                     rd_q    <= 1'b1;
                     raddr_q <= {blk_q, {BLK_ADDR_W{1'b0}}};
                     blk_q   <= blk_q + 1'b1;
                  end
               end else begin
                  usb_tx_half_o <= HALF_REPLY;
                  usb_tx_sop_o  <= 1'b1;
                  state_q       <= ST_TXBUF;
               end
            end
            ST_SDRAM: begin
               if (raddr_q[BLK_ADDR_W-1:0] != BLK_LAST) begin
                  rd_q    <= 1'b1;
                  raddr_q <= raddr_q + 1'b1;
               end
               if (sdram_rdv_i) begin
                  fill_q <= fill_q + 1'b1;
                  if (fill_q == BLK_LAST) begin
                     if (usb_full_i) begin
                        // FIFO full, drop block and read it again later
                        state_q <= ST_IDLE;
                        blk_q   <= blk_q - 1'b1;
                     end else begin
                        usb_tx_sop_o <= 1'b1;
                        state_q      <= ST_TXBUF;
                     end
                  end
               end
            end
            ST_TXBUF: begin
               if (eop_seen) begin
                  if (cmd_mode_q && !cmd_i.vd && !blk_match) begin
                     state_q <= ST_SDRAM;                     // More blocks to send
                     rd_q    <= 1'b1;
                     raddr_q <= {blk_q, {BLK_ADDR_W{1'b0}}};
                     blk_q   <= blk_q + 1'b1;
                  end else begin
                     state_q <= ST_IDLE;
                  end
               end
            end
            default: state_q <= ST_IDLE;
         endcase

         if (!acq_en_i)
            blk_q <= '0;                                      // Restart from block 0
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////
   a_rd_in_flow : assert property (
      @(posedge mclk) disable iff (rst_i)
      rd_q |-> ($past(state_q) != ST_IDLE)
   );

   a_sop_single : assert property (
      @(posedge mclk) disable iff (rst_i)
      usb_tx_sop_o |=> !usb_tx_sop_o
   );

endmodule

// ==== logic/adc_demo_top.sv ====
// ADC demo top level joining the sync generator, flow controller and transmit buffer
`timescale 1ns/1ps

module adc_demo_top
   import adc_demo_pkg::*;
#(
   parameter int SPCLK_DIV = MCLK_RATE / SPCLK_RATE
) (
   input  logic      mclk,
   input  logic      rst_i,
   // Control and command
   input  logic      acq_en_i,
   input  cmd_t      cmd_i,
   input  word_t     cmd_data_i,
   // SDRAM controller
   input  logic      sdram_wstatus_i,
   input  logic      sdram_rdv_i,
   input  word_t     sdram_rdata_i,
   output sdram_wr_t sdram_wr_o,
   output sdram_rd_t sdram_rd_o,
   // USB sender
   input  logic      usb_full_i,
   input  logic      usb_tx_eop_i,
   input  blk_addr_t usb_tx_addr_i,
   output logic      usb_tx_sop_o,
   output logic      usb_tx_half_o,
   output word_t     usb_tx_data_o,
   // Test signals
   output logic      spclk_o,
   output logic      sync_o,
   output logic      data_o
);

   logic                buf_we;
   logic [BLK_ADDR_W:0] buf_waddr;
   word_t               buf_wdata;

   ////////////////////////////////////////////////////////////
   // Test-signal generator
   ////////////////////////////////////////////////////////////
   sync_out_gen #(
      .SPCLK_DIV (SPCLK_DIV)
   ) u_sync_out_gen (
      .mclk    (mclk),
      .rst_i   (rst_i),
      .spclk_o (spclk_o),
      .sync_o  (sync_o),
      .data_o  (data_o)
   );

   ////////////////////////////////////////////////////////////
   // Flow control and buffer
   ////////////////////////////////////////////////////////////
   tx_flow_ctrl u_tx_flow_ctrl (
      .mclk            (mclk),
      .rst_i           (rst_i),
      .acq_en_i        (acq_en_i),
      .cmd_i           (cmd_i),
      .cmd_data_i      (cmd_data_i),
      .sdram_wstatus_i (sdram_wstatus_i),
      .sdram_rdv_i     (sdram_rdv_i),
      .sdram_rdata_i   (sdram_rdata_i),
      .usb_full_i      (usb_full_i),
      .usb_tx_eop_i    (usb_tx_eop_i),
      .sdram_wr_o      (sdram_wr_o),
      .sdram_rd_o      (sdram_rd_o),
      .usb_tx_sop_o    (usb_tx_sop_o),
      .usb_tx_half_o   (usb_tx_half_o),
      .buf_we_o        (buf_we),
      .buf_waddr_o     (buf_waddr),
      .buf_wdata_o     (buf_wdata)
   );

   tx_block_buffer u_tx_block_buffer (
      .mclk    (mclk),
      .we_i    (buf_we),
      .waddr_i (buf_waddr),
      .wdata_i (buf_wdata),
      .rhalf_i (usb_tx_half_o),   // Sender reads the half picked by the controller
      .raddr_i (usb_tx_addr_i),
      .rdata_o (usb_tx_data_o)
   );

endmodule

// ==== tests/tb_adc_demo_tasks.svh ====
// Check task and directed tests for the ADC demo testbench
`ifndef TB_ADC_DEMO_TASKS_SVH
`define TB_ADC_DEMO_TASKS_SVH

task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
   if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      $display("tests failed");
      $fatal(1, "Mismatch in %s", name);
   end
endtask

task automatic issue_cmd(input logic mode, input int addr, input word_t data);
   @(negedge mclk);
   cmd_i.vd         = 1'b1;
   cmd_i.sdram_mode = mode;
   cmd_i.addr       = sdram_addr_t'(addr);
   cmd_data_i       = data;
   @(negedge mclk);
   cmd_i = '0;
endtask

task automatic test_reset();
   check("reset rd", 0, sdram_rd_o.rd);
   check("reset wren", 0, sdram_wr_o.wren);
   check("reset sop", 0, usb_tx_sop_o);
   check("reset spclk", 0, spclk_o);
   check("reset sync", 0, sync_o);
   check("reset data", 0, data_o);
endtask

// Outputs follow the counters, which start at zero on the first edge out of reset
task automatic test_generator();
   int t;
   int sp;
   int fr;
   for (t = 0; t < GEN_CYCLES; t++) begin
      @(negedge mclk);
      sp = (t / TB_DIV) % SPCLK_PER_FRAME;
      fr = (t / (TB_DIV * SPCLK_PER_FRAME)) % FRAMES_PER_CYCLE;
      check("generator spclk", (t % TB_DIV) < TB_DIV / 2, spclk_o);
      check("generator sync", (sp == 0) && (fr < SYNC_MUTE_FIRST), sync_o);
      check("generator data", sp < DATA_HIGH_SPCLKS, data_o);
   end
endtask

task automatic test_direct_reply();
   int    addrs [4] = '{5, 1000, 1023, 0};
   word_t data;
   int    base;
   for (int k = 0; k < 4; k++) begin
      data = word_t'($random(seed));
      base = xfer_cnt;
      issue_cmd(1'b0, addrs[k], data);
      while (xfer_cnt == base)
         @(negedge mclk);
      check("direct half", HALF_REPLY, rx_half);
      check("direct word", data, rx_words[addrs[k]]);
      repeat (8) @(negedge mclk);   // EOP reaches the FSM
   end
endtask

// One sdram-mode command and the block transfers it should cause
task automatic run_block_cmd(input string name, input int cmd_blk, input int first_blk,
                             input int n_blk);
   int    base;
   int    waddr;
   word_t wdata;
   read_log.delete();
   base  = xfer_cnt;
   waddr = cmd_blk * BLK_WORDS + 17;
   wdata = word_t'($random(seed));
   issue_cmd(1'b1, waddr, wdata);
   check(name, wdata, sdram_mem[waddr]);   // Command word landed in SDRAM
   for (int b = 0; b < n_blk; b++) begin
      while (xfer_cnt < base + b + 1)
         @(negedge mclk);
      check(name, HALF_BLOCK, rx_half);
      for (int i = 0; i < BLK_WORDS; i++)
         check(name, sdram_mem[(first_blk + b) * BLK_WORDS + i], rx_words[i]);
   end
   repeat (8) @(negedge mclk);
   check(name, n_blk * BLK_WORDS, read_log.size());
   for (int i = 0; i < read_log.size(); i++)
      check(name, first_blk * BLK_WORDS + i, read_log[i]);
endtask

task automatic test_block_readout();
   run_block_cmd("block readout", 2, 0, 3);
endtask

task automatic test_back_pressure();
   int sops;
   usb_full_i = 1'b1;
   sops = sop_cnt;
   read_log.delete();
   issue_cmd(1'b1, 3 * BLK_WORDS + 40, word_t'($random(seed)));
   while (read_log.size() < BLK_WORDS || pend_addr.size() > 0)
      @(negedge mclk);
   repeat (8) @(negedge mclk);
   check("back pressure sop", sops, sop_cnt);
   check("back pressure reads", BLK_WORDS, read_log.size());
   usb_full_i = 1'b0;
   run_block_cmd("back pressure retry", 3, 3, 1);
endtask

task automatic test_block_clear();
   @(negedge mclk);
   acq_en_i = 1'b0;
   @(negedge mclk);
   acq_en_i = 1'b1;
   run_block_cmd("block clear", 1, 0, 2);
endtask

`endif

// ==== tests/tb_adc_demo.sv ====
// ADC demo testbench with SDRAM and USB responder models and directed tests
`timescale 1ns/1ps

module tb_adc_demo
   import adc_demo_pkg::*;
();

   localparam int TB_DIV         = 8;
   localparam int GEN_CYCLES     = TB_DIV * SPCLK_PER_FRAME * FRAMES_PER_CYCLE;
   localparam int TIMEOUT_CYCLES = 600_000;   // Sync cycle plus block transfers
   localparam int BLK_WORDS      = 2 ** BLK_ADDR_W;

   logic      mclk;
   logic      rst_i;
   logic      acq_en_i;
   cmd_t      cmd_i;
   word_t     cmd_data_i;
   logic      sdram_wstatus_i;
   logic      sdram_rdv_i;
   word_t     sdram_rdata_i;
   sdram_wr_t sdram_wr_o;
   sdram_rd_t sdram_rd_o;
   logic      usb_full_i;
   logic      usb_tx_eop_i;
   blk_addr_t usb_tx_addr_i;
   logic      usb_tx_sop_o;
   logic      usb_tx_half_o;
   word_t     usb_tx_data_o;
   logic      spclk_o;
   logic      sync_o;
   logic      data_o;

   int          seed = 32'h5f97d93c;
   int          cyc_cnt;
   word_t       sdram_mem [2 ** SDRAM_ADDR_W];
   sdram_addr_t read_log [$];          // Every read address, in issue order
   sdram_addr_t pend_addr [$];
   int          pend_due [$];
   word_t       rx_words [BLK_WORDS];  // Last block seen by the USB model
   logic        rx_half;
   int          xfer_cnt;
   int          sop_cnt;

   adc_demo_top #(
      .SPCLK_DIV (TB_DIV)
   ) u_dut (
      .mclk            (mclk),
      .rst_i           (rst_i),
      .acq_en_i        (acq_en_i),
      .cmd_i           (cmd_i),
      .cmd_data_i      (cmd_data_i),
      .sdram_wstatus_i (sdram_wstatus_i),
      .sdram_rdv_i     (sdram_rdv_i),
      .sdram_rdata_i   (sdram_rdata_i),
      .sdram_wr_o      (sdram_wr_o),
      .sdram_rd_o      (sdram_rd_o),
      .usb_full_i      (usb_full_i),
      .usb_tx_eop_i    (usb_tx_eop_i),
      .usb_tx_addr_i   (usb_tx_addr_i),
      .usb_tx_sop_o    (usb_tx_sop_o),
      .usb_tx_half_o   (usb_tx_half_o),
      .usb_tx_data_o   (usb_tx_data_o),
      .spclk_o         (spclk_o),
      .sync_o          (sync_o),
      .data_o          (data_o)
   );

   `include "tb_adc_demo_tasks.svh"

   initial begin
      mclk = 1'b0;
      forever #50 mclk = ~mclk;
   end

   ////////////////////////////////////////////////////////////
   // SDRAM model
   ////////////////////////////////////////////////////////////
   always begin : sdram_model
      int   mcyc;
      int   due;
      int   last_due;
      int   wcnt;
      logic wr_seen;
      @(posedge mclk);
      mcyc++;
      wr_seen = sdram_wr_o.wren;
      if (sdram_wr_o.wren)
         sdram_mem[sdram_wr_o.waddr] = sdram_wr_o.wdata;
      if (sdram_rd_o.rd) begin
         due = mcyc + 1 + ($unsigned($random(seed)) % 4);
         if (due <= last_due)
            due = last_due + 1;   // Keep request order
         last_due = due;
         pend_addr.push_back(sdram_rd_o.raddr);
         pend_due.push_back(due);
         read_log.push_back(sdram_rd_o.raddr);
      end
      @(negedge mclk);
      if (wr_seen) begin
         sdram_wstatus_i = 1'b0;
         wcnt = 2;
      end else if (wcnt > 0) begin
         wcnt--;
         if (wcnt == 0)
            sdram_wstatus_i = 1'b1;   // Write done
      end
      if (pend_due.size() > 0 && pend_due[0] <= mcyc) begin
         sdram_rdv_i   = 1'b1;
         sdram_rdata_i = sdram_mem[pend_addr[0]];
         void'(pend_due.pop_front());
         void'(pend_addr.pop_front());
      end else begin
         sdram_rdv_i = 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // USB sender model
   ////////////////////////////////////////////////////////////
   always begin : usb_model
      int i;
      @(posedge mclk);
      if (usb_tx_sop_o) begin
         rx_half = usb_tx_half_o;
         for (i = 0; i <= BLK_WORDS; i++) begin
            @(negedge mclk);
            if (i > 0)
               rx_words[i-1] = usb_tx_data_o;   // Data for previous address
            if (i < BLK_WORDS)
               usb_tx_addr_i = blk_addr_t'(i);
         end
         xfer_cnt++;
         usb_tx_eop_i = 1'b1;
         @(negedge mclk);
         usb_tx_eop_i = 1'b0;
      end
   end

   always @(posedge mclk) begin
      if (usb_tx_sop_o)
         sop_cnt <= sop_cnt + 1;
   end

   // Run limit
   always @(posedge mclk) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt >= TIMEOUT_CYCLES) begin
         $display("tests failed");
         $fatal(1, "Timeout, run exceeded %0d cycles", TIMEOUT_CYCLES);
      end
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      rst_i           = 1'b1;
      acq_en_i        = 1'b1;
      cmd_i           = '0;
      cmd_data_i      = '0;
      sdram_wstatus_i = 1'b0;
      sdram_rdv_i     = 1'b0;
      sdram_rdata_i   = '0;
      usb_full_i      = 1'b0;
      usb_tx_eop_i    = 1'b0;
      usb_tx_addr_i   = '0;
      cyc_cnt         = 0;
      xfer_cnt        = 0;
      sop_cnt         = 0;
      for (int a = 0; a < 2 ** SDRAM_ADDR_W; a++)
         sdram_mem[a] = word_t'($random(seed));

      repeat (10) @(negedge mclk);
      test_reset();
      rst_i = 1'b0;
      test_generator();
      test_direct_reply();
      test_block_readout();
      test_back_pressure();
      test_block_clear();
      $display("all tests passed");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+tests
logic/adc_demo_pkg.sv
logic/sync_out_gen.sv
logic/tx_block_buffer.sv
logic/tx_flow_ctrl.sv
logic/adc_demo_top.sv
tests/tb_adc_demo.sv

// ==== Makefile ====
TOP = tb_adc_demo

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
